/* memory_game_top.f */
src/game_pkg.sv
src/video_pkg.sv
src/match_ifs.sv
src/start_button.sv
src/key_tracker.sv
src/match_controller.sv
src/vga_timing.sv
src/tile_renderer.sv
src/memory_game_top.sv
tb/memory_game_props.sv
tb/memory_game_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the memory game testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module memory_game_tb \
    -f memory_game_top.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vmemory_game_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test passed" sim.log; then
    exit 0
fi
echo "Pass line not found in sim.log"
exit 1

/* tb/memory_game_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_game_tb import game_pkg::*, video_pkg::*; ();

    localparam int WAIT_LIMIT  = 200;
    localparam int LINE_LIMIT  = 1000;
    localparam int FRAME_LIMIT = 900000;

    logic        clk;
    logic        rst;
    logic        start_i;
    logic        hint_i;
    logic        key_make_i;
    logic        key_break_i;
    logic [8:0]  key_code_i;
    logic [3:0]  red_o;
    logic [3:0]  green_o;
    logic [3:0]  blue_o;
    logic        hsync_o;
    logic        vsync_o;
    logic        ready_o;
    logic        pass_o;
    game_state_t state_o;

    int          mismatches;
    int          timeouts;
    rgb_t        top_rgb [NUM_TILES];
    rgb_t        bot_rgb [NUM_TILES];
    rgb_t        blank_rgb;
    logic [15:0] good_m;
    logic [15:0] flip_m;

    memory_game_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .start_i     (start_i),
        .hint_i      (hint_i),
        .key_make_i  (key_make_i),
        .key_break_i (key_break_i),
        .key_code_i  (key_code_i),
        .red_o       (red_o),
        .green_o     (green_o),
        .blue_o      (blue_o),
        .hsync_o     (hsync_o),
        .vsync_o     (vsync_o),
        .ready_o     (ready_o),
        .state_o     (state_o),
        .pass_o      (pass_o)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic check_value(input string name, input int actual, input int expected);
        assert (actual == expected) else begin
            mismatches++;
            $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    // Colour at the centre of one half of a tile; a flip swaps the halves
    function automatic rgb_t expected_colour(input logic [3:0] tile, input logic vis,
                                             input logic flipped, input logic top_half);
        if (!vis) begin
            return 12'h000;
        end
        return (top_half ^ flipped) ? PALETTE[tile[2:0]] : 12'hfff;
    endfunction

    task automatic wait_state(input game_state_t target);
        int waited;
        waited = 0;
        while (state_o != target && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        assert (state_o == target) else begin
            timeouts++;
            $display("Timed out waiting for state %s", target.name());
        end
    endtask

    task automatic wait_ready(input logic level);
        int waited;
        waited = 0;
        while (ready_o != level && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        assert (ready_o == level) else begin
            timeouts++;
            $display("Timed out waiting for ready_o to become %0b", level);
        end
    endtask

    task automatic wait_pass_high();
        int waited;
        waited = 0;
        while (!pass_o && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        assert (pass_o) else begin
            timeouts++;
            $display("Timed out waiting for pass_o to rise");
        end
    endtask

    task automatic wait_sync_fall(input logic vertical);
        int   waited;
        int   limit;
        logic last;
        logic found;
        waited = 0;
        found  = 1'b0;
        limit  = vertical ? FRAME_LIMIT : LINE_LIMIT;
        while (!found && waited < limit) begin
            last = vertical ? vsync_o : hsync_o;
            @(negedge clk);
            waited++;
            found = last && !(vertical ? vsync_o : hsync_o);
        end
        assert (found) else begin
            timeouts++;
            $display("Timed out waiting for %s to fall", vertical ? "vsync_o" : "hsync_o");
        end
    endtask

    task automatic hold_start(input int cycles);
        start_i = 1'b1;
        repeat (cycles) @(negedge clk);
        start_i = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    task automatic strobe_key(input key_num_t key, input logic is_make);
        key_code_i  = SCAN_CODES[key];
        key_make_i  = is_make;
        key_break_i = !is_make;
        @(negedge clk);
        key_make_i  = 1'b0;
        key_break_i = 1'b0;
    endtask

    task automatic press_keys(input key_num_t first, input key_num_t second);
        strobe_key(first, 1'b1);
        strobe_key(second, 1'b1);
        repeat (2) @(negedge clk);
        strobe_key(first, 1'b0);
        strobe_key(second, 1'b0);
        repeat (2) @(negedge clk);
    endtask

    task automatic press_key(input key_num_t key);
        strobe_key(key, 1'b1);
        repeat (2) @(negedge clk);
        strobe_key(key, 1'b0);
        repeat (2) @(negedge clk);
    endtask

    task automatic reveal_and_clear(input key_num_t first, input key_num_t second);
        press_keys(first, second);
        wait_ready(1'b0);
        press_key(KEY_ENTER);
        wait_ready(1'b1);
    endtask

    // Line count restarts at the hsync falling edge in the line before each sampled row
    task automatic sample_frame();
        int         line;
        int         col;
        logic [3:0] tile_idx;
        wait_sync_fall(1'b1);
        blank_rgb = '0;
        // First hsync fall after vsync leads into line 490
        line = -36;
        while (line < 450) begin
            wait_sync_fall(1'b0);
            line++;
            if (line >= 0 && (line % 120 == 30 || line % 120 == 90)) begin
                blank_rgb = blank_rgb | {red_o, green_o, blue_o};
                repeat (224) @(negedge clk);
                for (col = 0; col < 4; col++) begin
                    tile_idx = 4'((line / 120) * 4 + col);
                    if (line % 120 == 30) begin
                        top_rgb[tile_idx] = {red_o, green_o, blue_o};
                    end else begin
                        bot_rgb[tile_idx] = {red_o, green_o, blue_o};
                    end
                    if (col < 3) begin
                        repeat (160) @(negedge clk);
                    end
                end
            end
        end
    endtask

    task automatic check_frame(input string label, input logic [15:0] vis,
                               input logic [15:0] flipped);
        int         t;
        logic [3:0] tile_idx;
        sample_frame();
        check_value({label, " blanking rgb"}, int'(blank_rgb), 0);
        for (t = 0; t < NUM_TILES; t++) begin
            tile_idx = 4'(t);
            check_value($sformatf("%s tile %0d top rgb", label, t), int'(top_rgb[tile_idx]),
                int'(expected_colour(tile_idx, vis[tile_idx], flipped[tile_idx], 1'b1)));
            check_value($sformatf("%s tile %0d bottom rgb", label, t), int'(bot_rgb[tile_idx]),
                int'(expected_colour(tile_idx, vis[tile_idx], flipped[tile_idx], 1'b0)));
        end
    endtask

    task automatic reset_and_short_press();
        check_value("state_o", int'(state_o), int'(INIT));
        check_value("pass_o", int'(pass_o), 0);
        check_value("ready_o", int'(ready_o), 1);
        check_value("hsync_o", int'(hsync_o), 1);
        check_value("vsync_o", int'(vsync_o), 1);
        check_value("rgb after reset", int'({red_o, green_o, blue_o}), 0);
        hold_start(6);
        repeat (20) @(negedge clk);
        check_value("state_o after short press", int'(state_o), int'(INIT));
    endtask

    // A second pulse here would skip SHOW
    task automatic held_start_advances_once();
        hold_start(40);
        wait_state(SHOW);
        repeat (20) @(negedge clk);
        check_value("state_o with start held", int'(state_o), int'(SHOW));
    endtask

    task automatic show_screen();
        check_frame("show", 16'hffff, flip_m);
        hold_start(10);
        wait_state(GAME);
    endtask

    task automatic pair_tiles();
        reveal_and_clear(5'd2, 5'd10);
        good_m[2]  = 1'b1;
        good_m[10] = 1'b1;
        press_keys(5'd3, 5'd4);
        wait_ready(1'b0);
        check_value("ready_o after pair", int'(ready_o), 0);
        check_frame("pair 3 4", good_m | 16'h0018, flip_m);
        press_key(KEY_ENTER);
        wait_ready(1'b1);
        check_frame("after enter", good_m, flip_m);
    endtask

    task automatic flip_and_hint();
        press_keys(KEY_SHIFT, 5'd0);
        wait_ready(1'b0);
        flip_m[0] = 1'b0;
        check_frame("tile 0 unflipped", good_m | 16'h0001, flip_m);
        press_key(KEY_ENTER);
        wait_ready(1'b1);
        hint_i = 1'b1;
        press_keys(5'd5, 5'd13);
        check_value("ready_o under hint", int'(ready_o), 1);
        check_frame("hint", 16'hffff, 16'h0000);
        hint_i = 1'b0;
        @(negedge clk);
        check_frame("after hint", good_m, flip_m);
    endtask

    task automatic win_and_restart();
        int p;
        reveal_and_clear(KEY_SHIFT, 5'd1);
        reveal_and_clear(KEY_SHIFT, 5'd13);
        reveal_and_clear(KEY_SHIFT, 5'd14);
        flip_m = '0;
        for (p = 0; p < 8; p++) begin
            if (p != 2) begin
                reveal_and_clear(5'(p), 5'(p + 8));
            end
        end
        wait_state(FINISH);
        wait_pass_high();
        check_frame("finish", 16'hffff, flip_m);
        hold_start(10);
        wait_state(INIT);
        check_value("pass_o after restart", int'(pass_o), 0);
        check_value("ready_o after restart", int'(ready_o), 1);
    endtask

    initial begin
        mismatches  = 0;
        timeouts    = 0;
        rst         = 1'b1;
        start_i     = 1'b0;
        hint_i      = 1'b0;
        key_make_i  = 1'b0;
        key_break_i = 1'b0;
        key_code_i  = '0;
        good_m      = '0;
        // Tiles 0, 1, 13 and 14 start upside down
        flip_m      = 16'b0110_0000_0000_0011;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        reset_and_short_press();
        held_start_advances_once();
        show_screen();
        pair_tiles();
        flip_and_hint();
        win_and_restart();

        $display("Checks done: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/memory_game_props.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_game_props import game_pkg::*, video_pkg::*; (
    input logic        clk,
    input logic        rst,
    input game_state_t state_i,
    input logic        pass_i,
    input logic        active_i,
    input logic [3:0]  red_i,
    input logic [3:0]  green_i,
    input logic [3:0]  blue_i,
    input logic        hsync_i
);
    logic [1:0] state_bits;
    logic [9:0] hsync_low_cnt;

    assign state_bits = state_i;

    // Length of the current hsync pulse
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hsync_low_cnt <= '0;
        end else if (!hsync_i) begin
            hsync_low_cnt <= hsync_low_cnt + 10'd1;
        end else begin
            hsync_low_cnt <= '0;
        end
    end

    // States only step forward and FINISH wraps to INIT
    state_order: assert property (@(posedge clk) disable iff (rst)
        (state_bits != $past(state_bits)) |-> (state_bits == $past(state_bits) + 2'd1))
        else $error("state_o made an illegal transition");

    pass_in_finish: assert property (@(posedge clk) disable iff (rst)
        pass_i |-> (state_i == FINISH))
        else $error("pass_o is high outside FINISH");

    black_blanking: assert property (@(posedge clk) disable iff (rst)
        !active_i |-> ({red_i, green_i, blue_i} == 12'h000))
        else $error("RGB is not black during blanking");

    hsync_width: assert property (@(posedge clk) disable iff (rst)
        $rose(hsync_i) |-> (hsync_low_cnt == H_SYNC))
        else $error("hsync_o pulse has the wrong width");

endmodule

bind memory_game_top memory_game_props i_props (
    .clk      (clk),
    .rst      (rst),
    .state_i  (state_o),
    .pass_i   (pass_o),
    .active_i (active),
    .red_i    (red_o),
    .green_i  (green_o),
    .blue_i   (blue_o),
    .hsync_i  (hsync_o)
);

`default_nettype wire

/* src/memory_game_top.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_game_top import game_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        start_i,
    input  logic        hint_i,
    input  logic        key_make_i,
    input  logic        key_break_i,
    input  logic [8:0]  key_code_i,
    output logic [3:0]  red_o,
    output logic [3:0]  green_o,
    output logic [3:0]  blue_o,
    output logic        hsync_o,
    output logic        vsync_o,
    output logic        ready_o,
    output game_state_t state_o,
    output logic        pass_o
);
    logic       start_pulse;
    logic [9:0] h_pos;
    logic [9:0] v_pos;
    logic       active;

    key_if   keys ();
    board_if board ();

    start_button i_start (
        .clk      (clk),
        .rst      (rst),
        .button_i (start_i),
        .press_o  (start_pulse)
    );

    key_tracker i_keys (
        .clk     (clk),
        .rst     (rst),
        .make_i  (key_make_i),
        .break_i (key_break_i),
        .code_i  (key_code_i),
        .keys    (keys.source)
    );

    match_controller i_ctrl (
        .clk     (clk),
        .rst     (rst),
        .start_i (start_pulse),
        .hint_i  (hint_i),
        .keys    (keys.sink),
        .board   (board.source),
        .state_o (state_o),
        .pass_o  (pass_o)
    );

    vga_timing i_vga (
        .clk      (clk),
        .rst      (rst),
        .h_pos_o  (h_pos),
        .v_pos_o  (v_pos),
        .active_o (active),
        .hsync_o  (hsync_o),
        .vsync_o  (vsync_o)
    );

    tile_renderer i_render (
        .h_pos_i  (h_pos),
        .v_pos_i  (v_pos),
        .active_i (active),
        .board    (board.sink),
        .red_o    (red_o),
        .green_o  (green_o),
        .blue_o   (blue_o)
    );

    assign ready_o = board.ready;

endmodule

`default_nettype wire

/* src/tile_renderer.sv */
`timescale 1ns/1ps
`default_nettype none

module tile_renderer import video_pkg::*; (
    input  logic [9:0] h_pos_i,
    input  logic [9:0] v_pos_i,
    input  logic       active_i,
    board_if.sink      board,
    output logic [3:0] red_o,
    output logic [3:0] green_o,
    output logic [3:0] blue_o
);
    tile_index_u tile;
    logic [9:0]  row_full;
    logic [9:0]  col_full;
    logic [9:0]  y_in_tile;
    logic [9:0]  img_y;
    logic [9:0]  art_y;
    logic        visible;
    rgb_t        pixel;

    assign row_full  = v_pos_i / TILE_H;
    assign col_full  = h_pos_i / TILE_W;
    assign y_in_tile = v_pos_i % TILE_H;
    assign img_y     = y_in_tile >> 1;

    always_comb begin
        tile.rc.row = row_full[1:0];
        tile.rc.col = col_full[1:0];
    end

    // Hint shows every image upright
    assign art_y = (board.flip[tile.flat] && !board.hint_active) ? IMG_H - 10'd1 - img_y : img_y;

    // Colour on top, white below, so a flip is visible
    assign pixel = (art_y < (IMG_H >> 1)) ? PALETTE[tile.flat[2:0]] : WHITE;

    assign visible = board.show[tile.flat] || board.good[tile.flat] || board.hint_active;

    assign {red_o, green_o, blue_o} = (active_i && visible) ? pixel : rgb_t'(0);

endmodule

`default_nettype wire

/* src/vga_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_timing import video_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    output logic [9:0] h_pos_o,
    output logic [9:0] v_pos_o,
    output logic       active_o,
    output logic       hsync_o,
    output logic       vsync_o
);
    logic [9:0] h_cnt;
    logic [9:0] v_cnt;
    logic       h_end;

    assign h_end = (h_cnt == H_TOTAL - 10'd1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            h_cnt <= h_end ? 10'd0 : h_cnt + 10'd1;
            if (h_end) begin
                v_cnt <= (v_cnt == V_TOTAL - 10'd1) ? 10'd0 : v_cnt + 10'd1;
            end
        end
    end

    // Sync pulses start one count early to line up with the registered output
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hsync_o <= 1'b1;
            vsync_o <= 1'b1;
        end else begin
            hsync_o <= !((h_cnt >= H_ACTIVE + H_FRONT - 10'd1) &&
                         (h_cnt < H_ACTIVE + H_FRONT + H_SYNC - 10'd1));
            vsync_o <= !((v_cnt >= V_ACTIVE + V_FRONT - 10'd1) &&
                         (v_cnt < V_ACTIVE + V_FRONT + V_SYNC - 10'd1));
        end
    end

    assign active_o = (h_cnt < H_ACTIVE) && (v_cnt < V_ACTIVE);
    assign h_pos_o  = (h_cnt < H_ACTIVE) ? h_cnt : 10'd0;
    assign v_pos_o  = (v_cnt < V_ACTIVE) ? v_cnt : 10'd0;

endmodule

`default_nettype wire

/* src/match_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module match_controller import game_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        start_i,
    input  logic        hint_i,
    key_if.sink         keys,
    board_if.source     board,
    output game_state_t state_o,
    output logic        pass_o
);
    game_state_t state;
    game_state_t next_state;
    logic [3:0]  match_cnt;
    logic        done;
    logic        both_held;
    logic        enter_held;
    logic        last_tile;
    logic        prev_tile;
    logic [3:0]  last_idx;
    logic [3:0]  prev_idx;
    logic        shift_pair;
    logic [3:0]  shift_idx;

    assign last_tile  = keys.last_key < KEY_SHIFT;
    assign prev_tile  = keys.prev_key < KEY_SHIFT;
    assign last_idx   = keys.last_key[3:0];
    assign prev_idx   = keys.prev_key[3:0];
    assign both_held  = keys.last_held && keys.prev_held && (keys.last_key != keys.prev_key);
    assign enter_held = (keys.last_held && keys.last_key == KEY_ENTER) ||
                        (keys.prev_held && keys.prev_key == KEY_ENTER);
    assign shift_pair = (keys.last_key == KEY_SHIFT && prev_tile) ||
                        (keys.prev_key == KEY_SHIFT && last_tile);
    assign shift_idx  = (keys.last_key == KEY_SHIFT) ? prev_idx : last_idx;

    assign board.hint_active = hint_i && (state == GAME);
    assign state_o = state;

    always_comb begin
        next_state = state;
        case (state)
            INIT:   if (start_i) next_state = SHOW;
            SHOW:   if (start_i) next_state = GAME;
            GAME:   if (done) next_state = FINISH;
            FINISH: if (start_i) next_state = INIT;
            default: next_state = INIT;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= INIT;
            pass_o      <= 1'b0;
            board.show  <= '0;
            board.good  <= '0;
            board.flip  <= '0;
            board.ready <= 1'b1;
            match_cnt   <= '0;
            done        <= 1'b0;
        end else begin
            state  <= next_state;
            pass_o <= (state == FINISH) && (next_state == FINISH);
            case (state)
                INIT: begin
                    board.show  <= '0;
                    board.good  <= '0;
                    board.flip  <= '0;
                    board.ready <= 1'b1;
                    match_cnt   <= '0;
                    done        <= 1'b0;
                end
                SHOW: begin
                    // Everything face up until the player starts
                    board.show  <= start_i ? '0 : '1;
                    board.good  <= '0;
                    board.flip  <= FLIP_AT_START;
                    board.ready <= 1'b1;
                end
                GAME: begin
                    if (!hint_i) begin
                        if (enter_held && !board.ready) begin
                            board.show  <= board.show & board.good;
                            board.ready <= 1'b1;
                            if (match_cnt == NUM_PAIRS) begin
                                done <= 1'b1;
                            end
                        end else if (both_held && board.ready && shift_pair) begin
                            if (!board.good[shift_idx]) begin
                                board.flip[shift_idx] <= !board.flip[shift_idx];
                                board.show[shift_idx] <= 1'b1;
                                board.ready           <= 1'b0;
                            end
                        end else if (both_held && board.ready && last_tile && prev_tile &&
                                     !board.good[last_idx] && !board.good[prev_idx]) begin
                            board.show[last_idx] <= 1'b1;
                            board.show[prev_idx] <= 1'b1;
                            board.ready          <= 1'b0;
                            // Image is tile index mod 8
                            if (last_idx[2:0] == prev_idx[2:0] &&
                                !board.flip[last_idx] && !board.flip[prev_idx]) begin
                                board.good[last_idx] <= 1'b1;
                                board.good[prev_idx] <= 1'b1;
                                match_cnt            <= match_cnt + 4'd1;
                            end
                        end
                    end
                end
                FINISH: begin
                    board.show  <= '1;
                    board.good  <= '1;
                    board.ready <= 1'b1;
                end
                default: board.ready <= 1'b1;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/key_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module key_tracker import game_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       make_i,
    input  logic       break_i,
    input  logic [8:0] code_i,
    key_if.source      keys
);
    logic [NUM_KEYS-1:0] held;
    key_num_t            code_key;

    function automatic logic held_flag(input logic [NUM_KEYS-1:0] flags, input key_num_t key);
        return (key < NUM_KEYS) ? flags[key] : 1'b0;
    endfunction

    // Scan code to key number
    always_comb begin
        code_key = KEY_NONE;
        for (int k = 0; k < NUM_KEYS; k++) begin
            if (code_i == SCAN_CODES[k]) begin
                code_key = key_num_t'(k);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            held          <= '0;
            keys.last_key <= KEY_NONE;
            keys.prev_key <= KEY_NONE;
        end else if (make_i && code_key != KEY_NONE) begin
            held[code_key] <= 1'b1;
            // Typematic repeats of the last key keep the pair intact
            if (code_key != keys.last_key) begin
                keys.prev_key <= keys.last_key;
                keys.last_key <= code_key;
            end
        end else if (break_i && code_key != KEY_NONE) begin
            held[code_key] <= 1'b0;
        end
    end

    assign keys.last_held = held_flag(held, keys.last_key);
    assign keys.prev_held = held_flag(held, keys.prev_key);

endmodule

`default_nettype wire

/* src/start_button.sv */
`timescale 1ns/1ps
`default_nettype none

module start_button import game_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic button_i,
    output logic press_o
);
    logic [DEBOUNCE_LEN-1:0] shift_q;
    logic                    stable;
    logic                    stable_q;

    // Pressed only once every stage agrees
    assign stable = &shift_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shift_q  <= '0;
            stable_q <= 1'b0;
            press_o  <= 1'b0;
        end else begin
            shift_q  <= {shift_q[DEBOUNCE_LEN-2:0], button_i};
            stable_q <= stable;
            press_o  <= stable && !stable_q;
        end
    end

endmodule

`default_nettype wire

/* src/match_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

// Last two keys seen by the tracker and whether each is still down
interface key_if import game_pkg::*; ();
    key_num_t last_key;
    key_num_t prev_key;
    logic     last_held;
    logic     prev_held;

    modport source (output last_key, prev_key, last_held, prev_held);
    modport sink (input last_key, prev_key, last_held, prev_held);
endinterface

// Per-tile board state as seen by the display
interface board_if import game_pkg::*; ();
    logic [NUM_TILES-1:0] show;
    logic [NUM_TILES-1:0] good;
    logic [NUM_TILES-1:0] flip;
    logic                 hint_active;
    logic                 ready;

    modport source (output show, good, flip, hint_active, ready);
    modport sink (input show, good, flip, hint_active);
endinterface

`default_nettype wire

/* src/video_pkg.sv */
`default_nettype none

package video_pkg;

    localparam logic [9:0] H_ACTIVE = 10'd640;
    localparam logic [9:0] H_FRONT  = 10'd16;
    localparam logic [9:0] H_SYNC   = 10'd96;
    localparam logic [9:0] H_TOTAL  = 10'd800;

    localparam logic [9:0] V_ACTIVE = 10'd480;
    localparam logic [9:0] V_FRONT  = 10'd10;
    localparam logic [9:0] V_SYNC   = 10'd2;
    localparam logic [9:0] V_TOTAL  = 10'd525;

    // Each tile holds an 80x60 image at double scale
    localparam logic [9:0] TILE_W = 10'd160;
    localparam logic [9:0] TILE_H = 10'd120;
    localparam logic [9:0] IMG_H  = 10'd60;

    typedef logic [11:0] rgb_t;

    localparam rgb_t WHITE = 12'hFFF;

    localparam rgb_t PALETTE [0:7] = '{
        12'hF00, 12'h0F0, 12'h00F, 12'hFF0,
        12'h0FF, 12'hF0F, 12'hF80, 12'h888
    };

    typedef struct packed {
        logic [1:0] row;
        logic [1:0] col;
    } tile_rc_t;

    typedef union packed {
        logic [3:0] flat;
        tile_rc_t   rc;
    } tile_index_u;

endpackage

`default_nettype wire

/* src/game_pkg.sv */
`default_nettype none

package game_pkg;

    typedef enum logic [1:0] {
        INIT   = 2'd0,
        SHOW   = 2'd1,
        GAME   = 2'd2,
        FINISH = 2'd3
    } game_state_t;

    localparam int NUM_TILES = 16;
    localparam logic [3:0] NUM_PAIRS = 4'd8;
    localparam int NUM_KEYS = 18;
    localparam int DEBOUNCE_LEN = 7;

    // 0 to 15 are tiles in row-major order
    typedef logic [4:0] key_num_t;
    localparam key_num_t KEY_SHIFT = 5'd16;
    localparam key_num_t KEY_ENTER = 5'd17;
    localparam key_num_t KEY_NONE  = 5'd31;

    // Set 2 make codes, indexed by key number
    localparam logic [8:0] SCAN_CODES [0:NUM_KEYS-1] = '{
        9'h016, 9'h01E, 9'h026, 9'h025,
        9'h015, 9'h01D, 9'h024, 9'h02D,
        9'h01C, 9'h01B, 9'h023, 9'h02B,
        9'h01A, 9'h022, 9'h021, 9'h02A,
        9'h012, 9'h05A
    };

    // Tiles 0, 1, 13 and 14
    localparam logic [NUM_TILES-1:0] FLIP_AT_START = 16'h6003;

endpackage

`default_nettype wire
